//--- vcache_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// size macros for the fetch cache
// include before the package and in any
// module that sizes arrays from them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VCACHE_MACROS_SVH
`define VCACHE_MACROS_SVH

// line and word widths
`define LINE_BITS 512
`define WORD_BITS 32

// fetch address fields
`define TAG_BITS 20
`define INDEX_BITS 6
`define OFFSET_BITS 4
`define LINE_ADDR_BITS (`TAG_BITS + `INDEX_BITS)

// victim entry count also works at 4 and 16
`define VC_CAPACITY 8

`endif

//--- vcache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the fetch cache
// fetch_addr_u gives the split view to the
// primary store and the line view elsewhere
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vcache_macros.svh"
`default_nettype none

package vcache_pkg;

    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

    // primary store view
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
    } fetch_split_t;

    // victim cache and memory view
    typedef struct packed {
        line_addr_t              line_addr;
        logic [`OFFSET_BITS-1:0] offset;
    } fetch_line_t;

    // one 30-bit word decoded two ways
    typedef union packed {
        fetch_split_t split;
        fetch_line_t  line;
    } fetch_addr_u;

endpackage

`default_nettype wire

//--- victim_port_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link between fetch controller and
// victim cache for lookup and write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface victim_port_if;

    // combinational lookup
    vcache_pkg::line_addr_t lookup_addr;
    logic                   hit;
    vcache_pkg::line_t      hit_line;

    // write port where swap selects the hitting slot
    logic                   wr_en;
    logic                   wr_swap;
    vcache_pkg::line_addr_t wr_addr;
    vcache_pkg::line_t      wr_line;

    modport ctrl (
        output lookup_addr,
        input  hit,
        input  hit_line,
        output wr_en,
        output wr_swap,
        output wr_addr,
        output wr_line
    );

    modport cache (
        input  lookup_addr,
        output hit,
        output hit_line,
        input  wr_en,
        input  wr_swap,
        input  wr_addr,
        input  wr_line
    );

endinterface

`default_nettype wire

//--- l1_line_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direct-mapped primary line store
// combinational read at the addressed index,
// line replacement on the next edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vcache_macros.svh"
`default_nettype none

module l1_line_store (
    input  logic                    clk,
    input  logic                    rstn,
    input  vcache_pkg::fetch_addr_u addr,
    output logic                    hit,
    output logic                    old_valid,
    output vcache_pkg::line_addr_t  old_line_addr,
    output vcache_pkg::line_t       rd_line,
    input  logic                    wr_en,
    input  vcache_pkg::line_t       wr_line
);

    localparam int DEPTH = 1 << `INDEX_BITS;

    logic [`TAG_BITS-1:0]   tag_q [DEPTH];
    vcache_pkg::line_t      data_q [DEPTH];
    logic [DEPTH-1:0]       valid_q;

    logic [`INDEX_BITS-1:0] idx;
    logic [`TAG_BITS-1:0]   req_tag;
    logic [`TAG_BITS-1:0]   cur_tag;

    assign idx     = addr.split.index;
    assign req_tag = addr.split.tag;
    assign cur_tag = tag_q[idx];

    // lookup at the index
    assign old_valid = valid_q[idx];
    assign hit       = valid_q[idx] && (cur_tag == req_tag);
    assign rd_line   = data_q[idx];

    // resident line address for eviction to the victim cache
    assign old_line_addr = {cur_tag, idx};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[idx]  <= req_tag;
            data_q[idx] <= wr_line;
        end
    end

endmodule

`default_nettype wire

//--- victim_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fully associative victim store
// parallel lookup, round-robin fill on evict,
// in-place overwrite of the hit slot on swap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vcache_macros.svh"
`default_nettype none

module victim_cache (
    input  logic         clk,
    input  logic         rstn,
    victim_port_if.cache vp
);

    localparam int CAPACITY  = `VC_CAPACITY;
    localparam int SLOT_BITS = $clog2(CAPACITY);

    vcache_pkg::line_addr_t tag_q [CAPACITY];
    vcache_pkg::line_t      data_q [CAPACITY];
    logic [CAPACITY-1:0]    valid_q;

    logic [CAPACITY-1:0]    match;
    logic [SLOT_BITS-1:0]   hit_slot;
    logic [SLOT_BITS-1:0]   rr_q;
    logic [SLOT_BITS-1:0]   wr_slot;

    // compare against every valid entry
    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == vp.lookup_addr);
        end
    end

    // lowest matching slot wins
    always_comb begin
        hit_slot = '0;
        for (int i = CAPACITY - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_slot = SLOT_BITS'(i);
            end
        end
    end

    assign vp.hit      = |match;
    assign vp.hit_line = data_q[hit_slot];

    // swap goes back into the slot that hit
    assign wr_slot = vp.wr_swap ? hit_slot : rr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (vp.wr_en) begin
            valid_q[wr_slot] <= 1'b1;
            // only a fresh eviction moves the pointer
            if (!vp.wr_swap) begin
                if (rr_q == SLOT_BITS'(CAPACITY - 1)) begin
                    rr_q <= '0;
                end else begin
                    rr_q <= rr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vp.wr_en) begin
            tag_q[wr_slot]  <= vp.wr_addr;
            data_q[wr_slot] <= vp.wr_line;
        end
    end

endmodule

`default_nettype wire

//--- fetch_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch FSM for lookup, victim swap and refill
// one fetch in flight, primary hit answers
// next cycle, swap in two, refill after memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vcache_macros.svh"
`default_nettype none

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  vcache_pkg::fetch_addr_u req_addr,
    output logic                    rsp_valid,
    output vcache_pkg::word_t       rsp_data,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output vcache_pkg::line_addr_t  mem_req_addr,
    input  logic                    mem_rsp_valid,
    input  vcache_pkg::line_t       mem_rsp_line,
    output vcache_pkg::fetch_addr_u l1_addr,
    input  logic                    l1_hit,
    input  logic                    l1_old_valid,
    input  vcache_pkg::line_addr_t  l1_old_line_addr,
    input  vcache_pkg::line_t       l1_rd_line,
    output logic                    l1_wr_en,
    output vcache_pkg::line_t       l1_wr_line,
    victim_port_if.ctrl             vp
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_SWAP     = 2'd1;
    localparam logic [1:0] ST_MEM_REQ  = 2'd2;
    localparam logic [1:0] ST_MEM_WAIT = 2'd3;

    logic [1:0]              state_q;
    vcache_pkg::fetch_addr_u addr_q;
    logic                    accept;
    logic                    in_swap;
    logic                    refill;
    logic                    fill;
    logic                    load_rsp;
    vcache_pkg::line_t       rsp_line;

    function automatic vcache_pkg::word_t pick_word(
        input vcache_pkg::line_t       line,
        input logic [`OFFSET_BITS-1:0] offset
    );
        return line[offset * `WORD_BITS +: `WORD_BITS];
    endfunction

    assign req_ready = (state_q == ST_IDLE);
    assign accept    = req_valid && req_ready;

    // idle looks up the incoming address, later states the held one
    assign l1_addr        = (state_q == ST_IDLE) ? req_addr : addr_q;
    assign vp.lookup_addr = l1_addr.line.line_addr;

    assign in_swap = (state_q == ST_SWAP);
    assign refill  = (state_q == ST_MEM_WAIT) && mem_rsp_valid;
    assign fill    = in_swap || refill;

    // new line into the primary store
    assign l1_wr_en   = fill;
    assign l1_wr_line = in_swap ? vp.hit_line : mem_rsp_line;

    // displaced primary line goes to the victim cache on the same edge
    assign vp.wr_en   = fill && l1_old_valid;
    assign vp.wr_swap = in_swap;
    assign vp.wr_addr = l1_old_line_addr;
    assign vp.wr_line = l1_rd_line;

    // response source per state
    assign load_rsp = (accept && l1_hit) || fill;
    always_comb begin
        case (state_q)
            ST_IDLE: rsp_line = l1_rd_line;
            ST_SWAP: rsp_line = vp.hit_line;
            default: rsp_line = mem_rsp_line;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q       <= ST_IDLE;
            rsp_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            rsp_valid <= load_rsp;
            case (state_q)
                ST_IDLE: begin
                    if (accept && !l1_hit) begin
                        if (vp.hit) begin
                            state_q <= ST_SWAP;
                        end else begin
                            state_q       <= ST_MEM_REQ;
                            mem_req_valid <= 1'b1;
                        end
                    end
                end
                ST_SWAP: begin
                    state_q <= ST_IDLE;
                end
                ST_MEM_REQ: begin
                    // hold the request until memory takes it
                    if (mem_req_ready) begin
                        mem_req_valid <= 1'b0;
                        state_q       <= ST_MEM_WAIT;
                    end
                end
                default: begin
                    if (mem_rsp_valid) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= req_addr;
            mem_req_addr <= req_addr.line.line_addr;
        end
        if (load_rsp) begin
            rsp_data <= pick_word(rsp_line, l1_addr.line.offset);
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read-only fetch cache top level
// primary store plus victim cache behind
// one fetch port and one line-wide memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module icache_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  vcache_pkg::fetch_addr_u req_addr,
    output logic                    rsp_valid,
    output vcache_pkg::word_t       rsp_data,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output vcache_pkg::line_addr_t  mem_req_addr,
    input  logic                    mem_rsp_valid,
    input  vcache_pkg::line_t       mem_rsp_line
);

    // primary store path
    vcache_pkg::fetch_addr_u l1_addr;
    logic                    l1_hit;
    logic                    l1_old_valid;
    vcache_pkg::line_addr_t  l1_old_line_addr;
    vcache_pkg::line_t       l1_rd_line;
    logic                    l1_wr_en;
    vcache_pkg::line_t       l1_wr_line;

    victim_port_if vp ();

    fetch_ctrl u_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_addr         (req_addr),
        .rsp_valid        (rsp_valid),
        .rsp_data         (rsp_data),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .mem_req_addr     (mem_req_addr),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_line     (mem_rsp_line),
        .l1_addr          (l1_addr),
        .l1_hit           (l1_hit),
        .l1_old_valid     (l1_old_valid),
        .l1_old_line_addr (l1_old_line_addr),
        .l1_rd_line       (l1_rd_line),
        .l1_wr_en         (l1_wr_en),
        .l1_wr_line       (l1_wr_line),
        .vp               (vp.ctrl)
    );

    l1_line_store u_l1 (
        .clk           (clk),
        .rstn          (rstn),
        .addr          (l1_addr),
        .hit           (l1_hit),
        .old_valid     (l1_old_valid),
        .old_line_addr (l1_old_line_addr),
        .rd_line       (l1_rd_line),
        .wr_en         (l1_wr_en),
        .wr_line       (l1_wr_line)
    );

    victim_cache u_vc (
        .clk  (clk),
        .rstn (rstn),
        .vp   (vp.cache)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// 10 ns clock, rstn low for two cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_icache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random fetch testbench for the cache
// memory model, reference model of both
// stores, per-fetch latency and data checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vcache_macros.svh"
`default_nettype none

module tb_icache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LIMIT = 64;
    localparam int CAP = `VC_CAPACITY;
    localparam int DEPTH = 1 << `INDEX_BITS;
    localparam int TAG_BASE = 'h80000;
    localparam vcache_pkg::word_t MEM_XOR = 32'h3c5a_a5c3;

    logic clk;
    logic rstn;
    logic req_valid;
    logic req_ready;
    vcache_pkg::fetch_addr_u req_addr;
    logic rsp_valid;
    vcache_pkg::word_t rsp_data;
    logic mem_req_valid;
    logic mem_req_ready;
    vcache_pkg::line_addr_t mem_req_addr;
    logic mem_rsp_valid;
    vcache_pkg::line_t mem_rsp_line;

    // reference model state
    logic [DEPTH-1:0] m_valid;
    logic [`TAG_BITS-1:0] m_tag [DEPTH];
    logic [CAP-1:0] v_valid;
    vcache_pkg::line_addr_t v_addr [CAP];
    int rr;

    logic [31:0] lfsr_q;
    int value_errors;
    int protocol_errors;
    int timeouts;

    tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

    icache_top i_dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic vcache_pkg::word_t mem_word(input vcache_pkg::line_addr_t la,
                                                   input logic [`OFFSET_BITS-1:0] w);
        return vcache_pkg::word_t'({la, w}) ^ MEM_XOR;
    endfunction

    function automatic vcache_pkg::line_t mem_line(input vcache_pkg::line_addr_t la);
        vcache_pkg::line_t line;
        logic [`OFFSET_BITS-1:0] w;
        for (int i = 0; i < (1 << `OFFSET_BITS); i++) begin
            w = i[`OFFSET_BITS-1:0];
            line[i*`WORD_BITS +: `WORD_BITS] = mem_word(la, w);
        end
        return line;
    endfunction

    function automatic vcache_pkg::fetch_addr_u make_addr(input int tag, input int idx,
                                                          input int off);
        vcache_pkg::fetch_addr_u a;
        a.split.tag    = tag[`TAG_BITS-1:0];
        a.split.index  = idx[`INDEX_BITS-1:0];
        a.split.offset = off[`OFFSET_BITS-1:0];
        return a;
    endfunction

    // small pools so lines keep colliding
    function automatic int pool_tag(input int i);
        case (i)
            0: return 'h0a1b2;
            1: return 'h13c4d;
            2: return 'h2e5f6;
            default: return 'hf0718;
        endcase
    endfunction

    function automatic int pool_index(input int i);
        case (i % 3)
            0: return 3;
            1: return 21;
            default: return 58;
        endcase
    endfunction

    // returns 0 on a primary hit, 1 on a victim hit, 2 on a miss
    // and updates both stores
    function automatic int model_access(input vcache_pkg::fetch_addr_u a);
        logic [`TAG_BITS-1:0] tag;
        logic [`INDEX_BITS-1:0] idx;
        vcache_pkg::line_addr_t old;
        int slot;
        int kind;
        tag = a.split.tag;
        idx = a.split.index;
        old = {m_tag[idx], idx};
        slot = -1;
        for (int s = CAP - 1; s >= 0; s--) begin
            if (v_valid[s] && v_addr[s] == a.line.line_addr) begin
                slot = s;
            end
        end
        if (m_valid[idx] && m_tag[idx] == tag) begin
            kind = 0;
        end else if (slot >= 0) begin
            kind = 1;
            if (m_valid[idx]) begin
                v_addr[slot] = old;
            end
        end else begin
            kind = 2;
            if (m_valid[idx]) begin
                v_addr[rr] = old;
                v_valid[rr] = 1'b1;
                rr = (rr + 1) % CAP;
            end
        end
        m_valid[idx] = 1'b1;
        m_tag[idx] = tag;
        return kind;
    endfunction

    task automatic check_word(input string name, input vcache_pkg::word_t got,
                              input vcache_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_line_addr(input string name, input vcache_pkg::line_addr_t got,
                                   input vcache_pkg::line_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        protocol_errors++;
        $display("%s", msg);
    endtask

    task automatic report_and_finish();
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // entered and left on a falling edge
    task automatic run_fetch(input vcache_pkg::fetch_addr_u a);
        vcache_pkg::line_addr_t la;
        int kind;
        int n;
        int stall;
        int delay;
        int rsp_at;
        logic mem_taken;
        logic done;
        // no further stimulus once a fetch has stalled
        if (timeouts > 0) begin
            return;
        end
        la = a.line.line_addr;
        kind = model_access(a);
        stall = take_bits(2);
        delay = 1 + take_bits(2);
        rsp_at = -1;
        mem_taken = 1'b0;
        done = 1'b0;
        req_valid = 1'b1;
        req_addr = a;
        n = 0;
        while (!req_ready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("fetch of line %h was never accepted", la);
        end else begin
            @(posedge clk);
            n = 0;
            while (!done && n < LIMIT) begin
                @(negedge clk);
                n++;
                req_valid = 1'b0;
                mem_rsp_valid = 1'b0;
                mem_req_ready = 1'b0;
                if (rsp_valid) begin
                    done = 1'b1;
                    check_word("rsp_data", rsp_data, mem_word(la, a.line.offset));
                    if (kind == 0 && n != 1) begin
                        note_failure($sformatf("primary hit answered after %0d cycles", n));
                    end else if (kind == 1 && n != 2) begin
                        note_failure($sformatf("victim hit answered after %0d cycles", n));
                    end else if (kind == 2 && (rsp_at < 0 || n != rsp_at + 1)) begin
                        note_failure($sformatf("miss of line %h answered out of turn", la));
                    end
                end else if (mem_req_valid) begin
                    if (kind != 2 || mem_taken) begin
                        note_failure($sformatf("unexpected memory request for line %h", la));
                    end
                    check_line_addr("mem_req_addr", mem_req_addr, la);
                    if (stall > 0) begin
                        stall--;
                    end else begin
                        mem_req_ready = 1'b1;
                        mem_taken = 1'b1;
                    end
                end else if (mem_taken && rsp_at < 0) begin
                    if (delay > 1) begin
                        delay--;
                    end else begin
                        mem_rsp_valid = 1'b1;
                        mem_rsp_line = mem_line(la);
                        rsp_at = n;
                    end
                end
            end
            if (!done) begin
                timeouts++;
                $display("no response for fetch of line %h", la);
            end
        end
    endtask

    initial begin
        int w;
        int t;
        int x;
        int o;
        lfsr_q = 32'hca37_7b72;
        value_errors = 0;
        protocol_errors = 0;
        timeouts = 0;
        m_valid = '0;
        v_valid = '0;
        rr = 0;
        req_valid = 1'b0;
        req_addr = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line = '0;
        w = 0;
        while (rstn !== 1'b1 && w < LIMIT) begin
            @(negedge clk);
            w++;
        end
        if (rstn !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
            report_and_finish();
        end else begin
            @(negedge clk);
            if (req_ready !== 1'b1 || rsp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
                note_failure("outputs not idle after reset");
            end
            // more evictions at one index than victim entries
            for (int i = 0; i < CAP + 2; i++) begin
                run_fetch(make_addr(TAG_BASE + i, 40, i));
            end
            // oldest victim is gone and goes to memory
            run_fetch(make_addr(TAG_BASE, 40, 1));
            // swap back and then fetch the displaced line
            run_fetch(make_addr(TAG_BASE + CAP + 1, 40, 2));
            run_fetch(make_addr(TAG_BASE, 40, 3));
            run_fetch(make_addr(TAG_BASE, 40, 4));
            for (int i = 0; i < 400; i++) begin
                t = take_bits(2);
                x = take_bits(2);
                o = take_bits(4);
                run_fetch(make_addr(pool_tag(t), pool_index(x), o));
            end
            report_and_finish();
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
vcache_pkg.sv
victim_port_if.sv
l1_line_store.sv
victim_cache.sv
fetch_ctrl.sv
icache_top.sv
tb_clkgen.sv
tb_icache.sv
